//--- bench/keeper_trace.txt
# xpos ypos is_scored round_counter score game_mode verdict, all hex
# verdict 2 = WINNER, 0 = START; target square x 14..1e, y 0c..16
19 11 0 1 0 1 2
14 0c 1 2 1 1 2
1e 16 0 3 1 0 2
13 11 0 4 2 1 0
1f 11 1 5 2 1 0
19 0b 0 6 3 0 0
19 17 0 7 3 1 0
1e 0c 1 8 4 1 2
14 16 0 9 4 0 2
13 0b 1 a 5 1 0
1f 17 0 b 5 1 0
28 28 0 c 6 0 0

//--- keeper.f
logic/keeper_pkg.sv
logic/vga_timing.sv
logic/signal_delay.sv
logic/draw_goal.sv
logic/keeper_round.sv
logic/glove_draw.sv
logic/keeper_top.sv
bench/keeper_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the keeper stage testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module keeper_tb \
    --Mdir obj_dir \
    -f keeper.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vkeeper_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

exit 0

//--- bench/keeper_tb.sv
/* keeper stage testbench: trace-driven keeper rounds checked against
   a reference model of the picture and the control word */

`timescale 1ns/1ns

module keeper_tb;

    localparam int H_ACTIVE    = 64;
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BACK      = 4;
    localparam int V_ACTIVE    = 48;
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 4;
    localparam int V_BACK      = 2;
    localparam int HORIZON     = 30;
    localparam int GOAL_LEFT   = 10;
    localparam int GOAL_RIGHT  = 53;
    localparam int GOAL_TOP    = 8;
    localparam int TARGET_X    = 20;
    localparam int TARGET_Y    = 12;
    localparam int TARGET_SIZE = 10;
    localparam int COUNT_TICKS = 5000;
    localparam int GLOVE_SIZE  = 4;
    localparam int MAX_GAP     = 200;
    localparam int FRAME_CLKS  = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
                                 (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

    // one trace line
    typedef struct packed {
        logic [11:0]           x;
        logic [11:0]           y;
        keeper_pkg::game_ctl_t ctl;
        keeper_pkg::g_state    verdict;
    } round_t;

    logic                  clk;
    logic                  rst;
    logic [11:0]           xpos;
    logic [11:0]           ypos;
    keeper_pkg::game_ctl_t ctl_in;
    keeper_pkg::vga_sig_t  vga_out;
    keeper_pkg::game_ctl_t ctl_out;

    round_t rounds[$];
    int     n_rounds;
    bit     round_active;
    int     target_hits;

    keeper_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .HORIZON (HORIZON), .GOAL_LEFT (GOAL_LEFT), .GOAL_RIGHT (GOAL_RIGHT),
        .GOAL_TOP (GOAL_TOP), .TARGET_X (TARGET_X), .TARGET_Y (TARGET_Y),
        .TARGET_SIZE (TARGET_SIZE), .COUNT_TICKS (COUNT_TICKS), .GLOVE_SIZE (GLOVE_SIZE)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .xpos    (xpos),
        .ypos    (ypos),
        .ctl_in  (ctl_in),
        .vga_out (vga_out),
        .ctl_out (ctl_out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_ctl(input string name, input keeper_pkg::game_ctl_t got,
                             input keeper_pkg::game_ctl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_rgb(input string name, input keeper_pkg::rgb_t got,
                             input keeper_pkg::rgb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_vid(input string name, input keeper_pkg::vga_sig_t got,
                             input keeper_pkg::vga_sig_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    function automatic bit on_glove(input int h, input int l);
        return h >= int'(xpos) && h < int'(xpos) + GLOVE_SIZE &&
               l >= int'(ypos) && l < int'(ypos) + GLOVE_SIZE;
    endfunction

    function automatic bit in_target(input int h, input int l);
        return h >= TARGET_X && h <= TARGET_X + TARGET_SIZE &&
               l >= TARGET_Y && l <= TARGET_Y + TARGET_SIZE;
    endfunction

    // syncs and blanking that belong to a pixel position
    function automatic keeper_pkg::vga_sig_t expected_timing(input logic [10:0] hc,
                                                             input logic [10:0] vc);
        keeper_pkg::vga_sig_t v;
        int h;
        int l;
        h        = int'(hc);
        l        = int'(vc);
        v        = '0;
        v.hcount = hc;
        v.vcount = vc;
        v.hsync  = h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC;
        v.vsync  = l >= V_ACTIVE + V_FRONT && l < V_ACTIVE + V_FRONT + V_SYNC;
        v.hblnk  = h >= H_ACTIVE;
        v.vblnk  = l >= V_ACTIVE;
        return v;
    endfunction

    // glove drawn over frame, sky and grass with no target
    function automatic keeper_pkg::rgb_t background_rgb(input keeper_pkg::vga_sig_t v);
        int h;
        int l;
        bit post;
        bit bar;
        h = int'(v.hcount);
        l = int'(v.vcount);
        post = l >= GOAL_TOP && l < HORIZON &&
               ((h >= GOAL_LEFT && h <= GOAL_LEFT + 3) ||
                (h >= GOAL_RIGHT - 3 && h <= GOAL_RIGHT));
        bar = l >= GOAL_TOP && l <= GOAL_TOP + 3 && h >= GOAL_LEFT && h <= GOAL_RIGHT;
        if (v.hblnk || v.vblnk) begin
            return '0;
        end else if (on_glove(h, l)) begin
            return keeper_pkg::GLOVE_RGB;
        end else if (post || bar) begin
            return keeper_pkg::FRAME_RGB;
        end else if (l < HORIZON) begin
            return keeper_pkg::SKY_RGB;
        end
        return keeper_pkg::GRASS_RGB;
    endfunction

    // outputs are read 1 ns past the edge, before new inputs go out
    task automatic step_and_check(input bit verdict_due, input keeper_pkg::g_state verdict);
        keeper_pkg::game_ctl_t exp_ctl;
        keeper_pkg::vga_sig_t  exp_vid;
        int h;
        int l;
        @(posedge clk);
        #1;
        exp_ctl = ctl_in;
        if (verdict_due) begin
            exp_ctl.game_state = verdict;
        end
        check_ctl("ctl_out", ctl_out, exp_ctl);
        h = int'(vga_out.hcount);
        l = int'(vga_out.vcount);
        exp_vid = expected_timing(vga_out.hcount, vga_out.vcount);
        exp_vid.rgb = background_rgb(exp_vid);
        if (round_active && vga_out.rgb == keeper_pkg::TARGET_RGB && !exp_vid.hblnk &&
            !exp_vid.vblnk && in_target(h, l) && !on_glove(h, l)) begin
            target_hits++;
            exp_vid.rgb = keeper_pkg::TARGET_RGB;
        end
        check_rgb($sformatf("vga_out.rgb at (%0d,%0d)", h, l), vga_out.rgb, exp_vid.rgb);
        check_vid("vga_out", vga_out, exp_vid);
    endtask

    task automatic read_trace();
        int     fd;
        string  line;
        int     f[7];
        round_t r;
        fd = $fopen("bench/keeper_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file bench/keeper_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]) != 7) begin
                abort_run($sformatf("trace line cannot be parsed: %s", line));
            end
            r.x                 = 12'(f[0]);
            r.y                 = 12'(f[1]);
            r.ctl.is_scored     = f[2][0];
            r.ctl.round_counter = 4'(f[3]);
            r.ctl.score         = 3'(f[4]);
            r.ctl.game_mode     = keeper_pkg::g_mode'(f[5][0]);
            r.ctl.game_state    = keeper_pkg::START;
            r.verdict           = keeper_pkg::g_state'(f[6][1:0]);
            rounds.push_back(r);
        end
        $fclose(fd);
        if (rounds.size() == 0) begin
            abort_run("the trace file holds no rounds");
        end
        n_rounds = rounds.size();
    endtask

    // each round gets its countdown, two frames and the longest idle gap
    initial begin
        int limit_ns;
        wait (n_rounds > 0);
        limit_ns = n_rounds * (COUNT_TICKS + 2 * FRAME_CLKS + MAX_GAP) * 10 +
                   2 * FRAME_CLKS * 10;
        #(limit_ns);
        abort_run("the run hung, watchdog time ran out");
    end

    initial begin
        round_t r;
        int     gap;
        void'($urandom(32'h33646502));
        rst          = 1'b1;
        xpos         = 12'd40;
        ypos         = 12'd40;
        ctl_in       = keeper_pkg::ctl_reset;
        round_active = 1'b0;
        target_hits  = 0;
        read_trace();

        // four reset cycles, then two empty pipeline slots
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #1;
            check_vid("vga_out", vga_out, '0);
            check_ctl("ctl_out", ctl_out, keeper_pkg::ctl_reset);
            if (i == 3) begin
                rst = 1'b0;
            end
        end

        repeat (FRAME_CLKS) step_and_check(1'b0, keeper_pkg::START);

        foreach (rounds[i]) begin
            r      = rounds[i];
            xpos   = r.x;
            ypos   = r.y;
            ctl_in = r.ctl;
            gap    = int'($urandom % (MAX_GAP + 1));
            repeat (gap) step_and_check(1'b0, keeper_pkg::START);

            ctl_in.game_state = keeper_pkg::KEEPER;
            round_active      = 1'b1;
            target_hits       = 0;
            // k = 0 is the edge that samples KEEPER
            for (int k = 0; k <= COUNT_TICKS + 3; k++) begin
                step_and_check(k == COUNT_TICKS + 3, r.verdict);
            end
            ctl_in.game_state = keeper_pkg::START;
            round_active      = 1'b0;
            if (target_hits == 0) begin
                abort_run($sformatf("round %0d never showed the target square", i));
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- logic/keeper_top.sv
/* penalty keeper stage: timing, pitch background,
   keeper round and glove overlay in one pipeline */

`timescale 1ns/1ns

module keeper_top #(
    parameter int H_ACTIVE    = 800,
    parameter int H_FRONT     = 40,
    parameter int H_SYNC      = 128,
    parameter int H_BACK      = 88,
    parameter int V_ACTIVE    = 600,
    parameter int V_FRONT     = 1,
    parameter int V_SYNC      = 4,
    parameter int V_BACK      = 23,
    parameter int HORIZON     = 400,
    parameter int GOAL_LEFT   = 150,
    parameter int GOAL_RIGHT  = 649,
    parameter int GOAL_TOP    = 120,
    parameter int TARGET_X    = 200,
    parameter int TARGET_Y    = 200,
    parameter int TARGET_SIZE = 100,
    parameter int COUNT_TICKS = 65000000,
    parameter int GLOVE_SIZE  = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    input  keeper_pkg::game_ctl_t ctl_in,
    output keeper_pkg::vga_sig_t  vga_out,
    output keeper_pkg::game_ctl_t ctl_out
);

    keeper_pkg::vga_sig_t vid_raw;
    keeper_pkg::vga_sig_t vid_bg;
    keeper_pkg::vga_sig_t vid_round;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (
        .clk (clk),
        .rst (rst),
        .vid (vid_raw)
    );

    draw_goal #(
        .HORIZON (HORIZON), .GOAL_LEFT (GOAL_LEFT),
        .GOAL_RIGHT (GOAL_RIGHT), .GOAL_TOP (GOAL_TOP)
    ) u_goal (
        .clk     (clk),
        .rst     (rst),
        .vid_in  (vid_raw),
        .vid_out (vid_bg)
    );

    keeper_round #(
        .TARGET_X (TARGET_X), .TARGET_Y (TARGET_Y),
        .TARGET_SIZE (TARGET_SIZE), .COUNT_TICKS (COUNT_TICKS)
    ) u_round (
        .clk     (clk),
        .rst     (rst),
        .vid_in  (vid_bg),
        .ctl_in  (ctl_in),
        .xpos    (xpos),
        .ypos    (ypos),
        .vid_out (vid_round),
        .ctl_out (ctl_out)
    );

    glove_draw #(
        .GLOVE_SIZE (GLOVE_SIZE)
    ) u_glove (
        .clk     (clk),
        .rst     (rst),
        .vid_in  (vid_round),
        .xpos    (xpos),
        .ypos    (ypos),
        .vid_out (vga_out)
    );

endmodule

//--- logic/glove_draw.sv
/* glove overlay: yellow square at the pointer over the picture,
   final registered video stage */

`timescale 1ns/1ns

module glove_draw #(
    parameter int GLOVE_SIZE = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  keeper_pkg::vga_sig_t vid_in,
    input  logic [11:0]          xpos,
    input  logic [11:0]          ypos,
    output keeper_pkg::vga_sig_t vid_out
);

    logic [12:0] x_end;
    logic [12:0] y_end;
    logic on_glove;

    // one past the last glove column and row, wide enough not to wrap
    assign x_end = {1'b0, xpos} + 13'(GLOVE_SIZE);
    assign y_end = {1'b0, ypos} + 13'(GLOVE_SIZE);

    assign on_glove = !vid_in.hblnk && !vid_in.vblnk &&
        ({2'b00, vid_in.hcount} >= {1'b0, xpos}) && ({2'b00, vid_in.hcount} < x_end) &&
        ({2'b00, vid_in.vcount} >= {1'b0, ypos}) && ({2'b00, vid_in.vcount} < y_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            vid_out <= '0;
        end else begin
            vid_out <= vid_in;
            if (on_glove) begin
                vid_out.rgb <= keeper_pkg::GLOVE_RGB;
            end
        end
    end

endmodule

//--- logic/keeper_round.sv
/* keeper round controller: counts down while showing a red target,
   then judges the pointer and rewrites the game state for one cycle */

`timescale 1ns/1ns

module keeper_round #(
    parameter int TARGET_X    = 200,
    parameter int TARGET_Y    = 200,
    parameter int TARGET_SIZE = 100,
    parameter int COUNT_TICKS = 65000000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  keeper_pkg::vga_sig_t  vid_in,
    input  keeper_pkg::game_ctl_t ctl_in,
    input  logic [11:0]           xpos,
    input  logic [11:0]           ypos,
    output keeper_pkg::vga_sig_t  vid_out,
    output keeper_pkg::game_ctl_t ctl_out
);

    localparam int CNT_W = $clog2(COUNT_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(COUNT_TICKS);

    // inclusive square bounds
    localparam logic [11:0] X_LO = 12'(TARGET_X);
    localparam logic [11:0] X_HI = 12'(TARGET_X + TARGET_SIZE);
    localparam logic [11:0] Y_LO = 12'(TARGET_Y);
    localparam logic [11:0] Y_HI = 12'(TARGET_Y + TARGET_SIZE);

    typedef enum logic [1:0] {
        IDLE,
        BEGIN,
        COUNTDOWN,
        RESULT
    } round_state_t;

    round_state_t state;
    round_state_t state_nxt;
    logic [CNT_W-1:0] cnt;

    logic pix_in_target;
    logic ptr_in_target;
    logic verdict_valid;
    keeper_pkg::g_state verdict;

    keeper_pkg::vga_sig_t  vid_paint;
    keeper_pkg::game_ctl_t ctl_rel_in;
    keeper_pkg::game_ctl_t ctl_rel_d;
    keeper_pkg::game_ctl_t ctl_d;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ctl_in.game_state == keeper_pkg::KEEPER) begin
                    state_nxt = BEGIN;
                end
            end
            BEGIN:     state_nxt = COUNTDOWN;
            COUNTDOWN: begin
                if (cnt == CNT_LAST) begin
                    state_nxt = RESULT;
                end
            end
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            cnt           <= '0;
            verdict_valid <= 1'b0;
        end else begin
            state         <= state_nxt;
            verdict_valid <= (state == RESULT);
            if (state == COUNTDOWN && cnt != CNT_LAST) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    assign ptr_in_target = (xpos >= X_LO) && (xpos <= X_HI) &&
                           (ypos >= Y_LO) && (ypos <= Y_HI);

    always_ff @(posedge clk) begin
        verdict <= ptr_in_target ? keeper_pkg::WINNER : keeper_pkg::START;
    end

    assign pix_in_target = !vid_in.hblnk && !vid_in.vblnk &&
        ({1'b0, vid_in.hcount} >= X_LO) && ({1'b0, vid_in.hcount} <= X_HI) &&
        ({1'b0, vid_in.vcount} >= Y_LO) && ({1'b0, vid_in.vcount} <= Y_HI);

    always_comb begin
        vid_paint = vid_in;
        if (state == COUNTDOWN && pix_in_target) begin
            vid_paint.rgb = keeper_pkg::TARGET_RGB;
        end
    end

    signal_delay #(
        .payload_t (keeper_pkg::vga_sig_t),
        .DEPTH     (1)
    ) u_vid_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (vid_paint),
        .dout (vid_out)
    );

    // kept relative to ctl_reset so that a cleared stage reads back as ctl_reset
    assign ctl_rel_in = keeper_pkg::game_ctl_t'(ctl_in ^ keeper_pkg::ctl_reset);

    signal_delay #(
        .payload_t (keeper_pkg::game_ctl_t),
        .DEPTH     (1)
    ) u_ctl_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (ctl_rel_in),
        .dout (ctl_rel_d)
    );

    assign ctl_d = keeper_pkg::game_ctl_t'(ctl_rel_d ^ keeper_pkg::ctl_reset);

    always_comb begin
        ctl_out = ctl_d;
        if (verdict_valid) begin
            ctl_out.game_state = verdict;
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst) cnt <= CNT_LAST)
        else $error("countdown counter above COUNT_TICKS");

    a_result_order: assert property (@(posedge clk) disable iff (rst)
        state == RESULT |-> $past(state) == COUNTDOWN)
        else $error("RESULT entered without COUNTDOWN");

endmodule

//--- logic/draw_goal.sv
/* pitch background: sky above the horizon, grass below
   and a white goal frame of two posts and a crossbar */

`timescale 1ns/1ns

module draw_goal #(
    parameter int HORIZON    = 400,
    parameter int GOAL_LEFT  = 150,
    parameter int GOAL_RIGHT = 649,
    parameter int GOAL_TOP   = 120
) (
    input  logic                 clk,
    input  logic                 rst,
    input  keeper_pkg::vga_sig_t vid_in,
    output keeper_pkg::vga_sig_t vid_out
);

    localparam logic [10:0] HOR     = 11'(HORIZON);
    localparam logic [10:0] L_LO    = 11'(GOAL_LEFT);
    localparam logic [10:0] L_HI    = 11'(GOAL_LEFT + 3);
    localparam logic [10:0] R_LO    = 11'(GOAL_RIGHT - 3);
    localparam logic [10:0] R_HI    = 11'(GOAL_RIGHT);
    localparam logic [10:0] TOP     = 11'(GOAL_TOP);
    localparam logic [10:0] BAR_BOT = 11'(GOAL_TOP + 3);

    logic post_rows;
    logic on_post;
    logic on_bar;
    keeper_pkg::rgb_t rgb_nxt;

    assign post_rows = (vid_in.vcount >= TOP) && (vid_in.vcount < HOR);

    assign on_post = post_rows &&
        (((vid_in.hcount >= L_LO) && (vid_in.hcount <= L_HI)) ||
         ((vid_in.hcount >= R_LO) && (vid_in.hcount <= R_HI)));

    assign on_bar = (vid_in.vcount >= TOP) && (vid_in.vcount <= BAR_BOT) &&
        (vid_in.hcount >= L_LO) && (vid_in.hcount <= R_HI);

    always_comb begin
        if (vid_in.hblnk || vid_in.vblnk) begin
            rgb_nxt = '0;
        end else if (on_post || on_bar) begin
            rgb_nxt = keeper_pkg::FRAME_RGB;
        end else if (vid_in.vcount < HOR) begin
            rgb_nxt = keeper_pkg::SKY_RGB;
        end else begin
            rgb_nxt = keeper_pkg::GRASS_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid_out <= '0;
        end else begin
            vid_out     <= vid_in;
            vid_out.rgb <= rgb_nxt;
        end
    end

endmodule

//--- logic/signal_delay.sv
/* fixed-depth delay line for any packed payload,
   every stage cleared on reset */

`timescale 1ns/1ns

module signal_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

//--- logic/vga_timing.sv
/* vga timing generator: pixel and line counters,
   registered syncs and blanking with a black pixel */

`timescale 1ns/1ns

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic                 clk,
    input  logic                 rst,
    output keeper_pkg::vga_sig_t vid
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam logic [10:0] H_LAST   = 11'(H_TOTAL - 1);
    localparam logic [10:0] V_LAST   = 11'(V_TOTAL - 1);
    localparam logic [10:0] H_ACT    = 11'(H_ACTIVE);
    localparam logic [10:0] V_ACT    = 11'(V_ACTIVE);
    localparam logic [10:0] HS_START = 11'(H_ACTIVE + H_FRONT);
    localparam logic [10:0] HS_END   = 11'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [10:0] VS_START = 11'(V_ACTIVE + V_FRONT);
    localparam logic [10:0] VS_END   = 11'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [10:0] hcnt;
    logic [10:0] vcnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_LAST) begin
            hcnt <= '0;
            vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 11'd1;
        end else begin
            hcnt <= hcnt + 11'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid <= '0;
        end else begin
            vid.hcount <= hcnt;
            vid.vcount <= vcnt;
            vid.hsync  <= (hcnt >= HS_START) && (hcnt < HS_END);
            vid.vsync  <= (vcnt >= VS_START) && (vcnt < VS_END);
            vid.hblnk  <= (hcnt >= H_ACT);
            vid.vblnk  <= (vcnt >= V_ACT);
            vid.rgb    <= '0;
        end
    end

    // line counter wraps before the total width
    a_hcnt_range: assert property (@(posedge clk) disable iff (rst) hcnt <= H_LAST)
        else $error("hcount reached total width");

endmodule

//--- logic/keeper_pkg.sv
/* keeper stage types: video and game-control words,
   game enums and the colour palette */

package keeper_pkg;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one pixel with its timing, 38 bits
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        rgb_t        rgb;
    } vga_sig_t;

    typedef enum logic [1:0] {
        START,
        KEEPER,
        WINNER,
        SHOOT
    } g_state;

    typedef enum logic {
        SINGLE,
        MULTI
    } g_mode;

    typedef struct packed {
        logic       is_scored;
        logic [3:0] round_counter;
        logic [2:0] score;
        g_mode      game_mode;
        g_state     game_state;
    } game_ctl_t;

    localparam game_ctl_t ctl_reset = '{
        is_scored:     1'b0,
        round_counter: 4'd0,
        score:         3'd0,
        game_mode:     MULTI,
        game_state:    START
    };

    localparam rgb_t SKY_RGB    = 12'h48F;
    localparam rgb_t GRASS_RGB  = 12'h2A2;
    localparam rgb_t FRAME_RGB  = 12'hFFF;
    localparam rgb_t TARGET_RGB = 12'hF00;
    localparam rgb_t GLOVE_RGB  = 12'hFF0;

endpackage
